// File: tb.f
source/riscv_isa_pkg.sv
source/fetch_pkg.sv
source/predecoder.sv
source/branch_compare.sv
source/address_generator.sv
source/register_file.sv
source/fetch_control.sv
source/fetch_unit.sv
bench/fetch_unit_properties.sv
bench/fetch_unit_tb.sv

// File: bench/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
();

  localparam int handshake_timeout = 100;
  localparam int run_timeout       = 5000;
  localparam int quiet_window      = 50; // Cycles watched for req after halt.

  typedef struct packed {
    logic [31:0] instr;
    logic        jump;
    logic [31:0] target;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] next_pc;
  } issue_record_type;

  logic        clock;
  logic        reset;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_ack;
  logic [31:0] imem_rdata;
  logic        imem_error;
  logic        issue_valid;
  logic [31:0] issue_pc;
  logic [31:0] issue_instr;
  logic        issue_jump;
  logic [31:0] issue_target;
  logic        issue_exception;
  logic [3:0]  issue_ecause;
  logic        wb_enable;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        halted;

  logic [31:0] memory_words [0:1023];
  bit          fault_map [0:1023];
  logic [31:0] shadow_regs [0:31];
  logic [31:0] expected_pc;
  int          value_errors = 0;
  int          other_errors = 0;
  int          record_count = 0;
  int          exception_count = 0;
  int          trap_count = 0;
  bit          halt_pending = 0;
  bit          wrote_last = 0;

  fetch_unit uut (
    .clock, .reset,
    .imem_req, .imem_addr, .imem_ack, .imem_rdata, .imem_error,
    .issue_valid, .issue_pc, .issue_instr, .issue_jump, .issue_target,
    .issue_exception, .issue_ecause,
    .wb_enable, .wb_addr, .wb_data, .halted
  );

  always #5 clock = ~clock;

  task automatic report_mismatch(string name, logic [31:0] pc, logic [31:0] want,
                                 logic [31:0] got);
    $display("ERROR %s at pc %h: expected %h, actual %h", name, pc, want, got);
    value_errors++;
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    other_errors++;
  endtask

  task automatic write_register(logic [4:0] addr, logic [31:0] data);
    wb_enable = 1'b1;
    wb_addr = addr;
    wb_data = data;
    if (addr != 5'd0) shadow_regs[addr] = data;
  endtask

  ////////////////////
  // Program building.

  function automatic logic [31:0] encode_itype(logic [6:0] op, logic [4:0] rd,
                                               logic [2:0] f3, logic [4:0] rs1,
                                               logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_btype(logic [2:0] f3, logic [4:0] rs1,
                                               logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcode_branch};
  endfunction

  function automatic logic [31:0] encode_jtype(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
  endfunction

  task automatic put_word(logic [31:0] addr, logic [31:0] word);
    memory_words[addr[11:2]] = word;
  endtask

  task automatic load_program();
    logic [2:0] f3;
    for (int i = 0; i < 1024; i++) begin
      memory_words[i] = encode_itype(opcode_op_imm, 5'd0, 3'b000, 5'd0, 12'(i)); // addi x0,x0,i.
      fault_map[i] = 1'b0;
    end
    put_word(32'h000, encode_itype(opcode_op_imm, 5'd3, 3'b000, 5'd1, 12'h123));
    put_word(32'h004, {20'h12345, 5'd4, opcode_lui});
    put_word(32'h008, encode_itype(opcode_load, 5'd2, 3'b010, 5'd1, 12'd8));
    put_word(32'h00c, encode_jtype(5'd1, 21'h14));                           // To 0x20.
    put_word(32'h020, encode_itype(opcode_jalr, 5'd0, 3'b000, 5'd0, 12'h041)); // To 0x40.
    // Each condition on (x1,x1), (x1,x2) and (x2,x1); both paths meet again.
    for (int k = 0; k < 18; k++) begin
      case (k / 3)
        0: f3 = funct3_beq;
        1: f3 = funct3_bne;
        2: f3 = funct3_blt;
        3: f3 = funct3_bge;
        4: f3 = funct3_bltu;
        default: f3 = funct3_bgeu;
      endcase
      put_word(32'h040 + 8 * k,
               encode_btype(f3, (k % 3 == 2) ? 5'd2 : 5'd1, (k % 3 == 1) ? 5'd2 : 5'd1, 13'd8));
      put_word(32'h044 + 8 * k, encode_itype(opcode_op_imm, 5'd6, 3'b000, 5'd1, 12'(k)));
    end
    put_word(32'h0d0, encode_btype(funct3_beq, 5'd0, 5'd0, 13'd6)); // Misaligned.
    put_word(trap_vector, encode_itype(opcode_jalr, 5'd0, 3'b000, 5'd5, 12'd0));
    put_word(32'h200, 32'hffff_ffff);                               // Undefined opcode.
    put_word(32'h300, encode_itype(opcode_op_imm, 5'd7, 3'b000, 5'd1, 12'hfff));
    fault_map[32'h304 >> 2] = 1'b1;
    put_word(32'h400, ebreak_instr);
  endtask

  ////////////////////
  // Reference model.

  function automatic issue_record_type expected_issue(input logic [31:0] pc,
                                                      input logic [31:0] word,
                                                      input bit fault,
                                                      input logic [31:0] regs [0:31]);
    issue_record_type r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] dest;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    bit          legal;
    bit          jumps;
    r = '0;
    r.instr = fault ? nop_instr : word;
    a = regs[r.instr[19:15]];
    b = regs[r.instr[24:20]];
    imm_b = {{19{r.instr[31]}}, r.instr[31], r.instr[7], r.instr[30:25], r.instr[11:8], 1'b0};
    imm_j = {{11{r.instr[31]}}, r.instr[31], r.instr[19:12], r.instr[20], r.instr[30:21], 1'b0};
    legal = 1'b1;
    jumps = 1'b0;
    dest = '0;
    case (r.instr[6:0])
      opcode_jal: begin
        jumps = 1'b1;
        dest = pc + imm_j;
      end
      opcode_jalr: begin
        jumps = 1'b1;
        dest = (a + {{20{r.instr[31]}}, r.instr[31:20]}) & ~32'd1;
      end
      opcode_branch: begin
        dest = pc + imm_b;
        case (r.instr[14:12])
          funct3_beq:  jumps = (a == b);
          funct3_bne:  jumps = (a != b);
          funct3_blt:  jumps = ($signed(a) < $signed(b));
          funct3_bge:  jumps = ($signed(a) >= $signed(b));
          funct3_bltu: jumps = (a < b);
          funct3_bgeu: jumps = (a >= b);
          default:     legal = 1'b0;
        endcase
      end
      opcode_lui, opcode_auipc, opcode_op_imm, opcode_op,
      opcode_load, opcode_store, opcode_system: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    if (jumps) r.target = dest;
    if (fault) begin
      r.exception = 1'b1;
      r.ecause = ecause_access_fault;
    end else if (!legal) begin
      r.exception = 1'b1;
      r.ecause = ecause_illegal_instr;
    end else if (jumps && dest[1]) begin
      r.exception = 1'b1;
      r.ecause = ecause_misaligned_target;
    end
    r.jump = jumps && !r.exception;
    if (r.exception) r.next_pc = trap_vector;
    else if (jumps) r.next_pc = dest;
    else r.next_pc = pc + 32'd4;
    return r;
  endfunction

  ////////////////////
  // Memory model.

  initial begin : memory_model
    int cycles;
    forever begin
      cycles = 0;
      @(negedge clock);
      while (imem_req !== 1'b1 && cycles < handshake_timeout) begin
        @(negedge clock);
        cycles++;
      end
      if (imem_req !== 1'b1) begin
        report_failure("Memory model saw no fetch request before its timeout");
      end else begin
        if (imem_addr !== expected_pc) begin
          report_mismatch("imem_addr", expected_pc, expected_pc, imem_addr);
        end
        repeat ($urandom_range(5, 0)) @(negedge clock);
        imem_error = fault_map[imem_addr[11:2]];
        imem_rdata = imem_error ? $urandom : memory_words[imem_addr[11:2]];
        imem_ack = 1'b1;
        cycles = 0;
        while (imem_req === 1'b1 && cycles < handshake_timeout) begin
          @(negedge clock);
          cycles++;
        end
        if (imem_req === 1'b1) report_failure("imem_req never dropped after imem_ack");
        repeat ($urandom_range(3, 0)) @(negedge clock);
        imem_ack = 1'b0;
        imem_error = 1'b0;
      end
    end
  end

  // Random writes in issue cycles exercise the write-first path. Each trap
  // instead points x5 at the next block, which the jalr at the trap vector uses.
  always @(negedge clock) begin : writeback_driver
    if (wrote_last) begin
      wb_enable = 1'b0;
      wrote_last = 1'b0;
    end
    if (issue_valid === 1'b1 && issue_exception === 1'b1) begin
      write_register(5'd5, 32'h200 + 32'h100 * trap_count);
      trap_count++;
      wrote_last = 1'b1;
    end else if (issue_valid === 1'b1 && $urandom_range(1, 0) == 1) begin
      write_register(5'($urandom_range(4, 1)), $urandom);
      wrote_last = 1'b1;
    end
  end

  ////////////////////
  // Checking.

  always @(posedge clock) begin : issue_check
    issue_record_type want;
    if (halt_pending) begin
      halt_pending = 0;
      if (halted !== 1'b1) report_failure("halted did not rise after ebreak issued");
    end
    if (reset === 1'b0 && issue_valid === 1'b1) begin
      want = expected_issue(expected_pc, memory_words[expected_pc[11:2]],
                            fault_map[expected_pc[11:2]], shadow_regs);
      record_count++;
      if (issue_pc !== expected_pc) begin
        report_mismatch("issue_pc", expected_pc, expected_pc, issue_pc);
      end
      if (issue_instr !== want.instr) begin
        report_mismatch("issue_instr", expected_pc, want.instr, issue_instr);
      end
      if (issue_jump !== want.jump) begin
        report_mismatch("issue_jump", expected_pc, want.jump, issue_jump);
      end
      if (issue_target !== want.target) begin
        report_mismatch("issue_target", expected_pc, want.target, issue_target);
      end
      if (issue_exception !== want.exception) begin
        report_mismatch("issue_exception", expected_pc, want.exception, issue_exception);
      end
      if (want.exception && issue_ecause !== want.ecause) begin
        report_mismatch("issue_ecause", expected_pc, want.ecause, issue_ecause);
      end
      if (want.exception) exception_count++;
      if (want.instr == ebreak_instr && !want.exception) halt_pending = 1;
      expected_pc = want.next_pc;
    end
  end

  initial begin : main
    int  cycles;
    bit  req_seen;
    void'($urandom(32'h748c_c41f));
    clock = 1'b0;
    reset = 1'b1;
    imem_ack = 1'b0;
    imem_rdata = '0;
    imem_error = 1'b0;
    wb_enable = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    expected_pc = reset_vector;
    for (int r = 0; r < 32; r++) shadow_regs[r] = '0;
    load_program();
    for (int r = 1; r <= 4; r++) begin // Preload through wb while in reset.
      write_register(5'(r), $urandom);
      @(negedge clock);
    end
    wb_enable = 1'b0;
    reset = 1'b0;
    cycles = 0;
    while (halted !== 1'b1 && cycles < run_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (halted !== 1'b1) begin
      report_failure("Timeout: the fetch unit never halted");
    end else begin
      req_seen = 0;
      for (int c = 0; c < quiet_window; c++) begin
        @(negedge clock);
        if (imem_req !== 1'b0) req_seen = 1;
      end
      if (req_seen) report_failure("imem_req appeared after the fetch unit halted");
    end
    if (exception_count != 3) report_failure("Three exceptions were expected on this program");
    other_errors += uut.handshake_checks.failure_count;
    $display("Checked %0d records: %0d value errors, %0d other errors",
             record_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/fetch_unit_properties.sv
`default_nettype none

module fetch_unit_properties
  import riscv_isa_pkg::*;
(
  input logic            clock,
  input logic            reset,
  input logic            imem_req,
  input logic            imem_ack,
  input logic [xlen-1:0] imem_addr,
  input logic            issue_valid,
  input logic            halted
);

  int failure_count = 0; // Read by the testbench at the end of the run.

  ////////////////////
  // Memory handshake.

  req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
    imem_req && !imem_ack |=> imem_req)
  else begin
    failure_count++;
    $error("imem_req dropped before imem_ack");
  end

  no_req_rise_during_ack: assert property (@(posedge clock) disable iff (reset)
    !imem_req && imem_ack |=> !imem_req)
  else begin
    failure_count++;
    $error("imem_req rose while imem_ack was high");
  end

  addr_stable_during_req: assert property (@(posedge clock) disable iff (reset)
    imem_req ##1 imem_req |-> $stable(imem_addr))
  else begin
    failure_count++;
    $error("imem_addr changed while imem_req was high");
  end

  ////////////////////
  // Issue and halt.

  issue_single_pulse: assert property (@(posedge clock) disable iff (reset)
    issue_valid |=> !issue_valid)
  else begin
    failure_count++;
    $error("issue_valid lasted two cycles");
  end

  no_req_when_halted: assert property (@(posedge clock) disable iff (reset)
    halted |-> !imem_req)
  else begin
    failure_count++;
    $error("imem_req seen while halted");
  end

endmodule

bind fetch_unit fetch_unit_properties handshake_checks (
  .clock(clock), .reset(reset),
  .imem_req(imem_req), .imem_ack(imem_ack), .imem_addr(imem_addr),
  .issue_valid(issue_valid), .halted(halted)
);

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

module fetch_unit
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  output logic            imem_req,
  output logic [xlen-1:0] imem_addr,
  input  logic            imem_ack,
  input  logic [xlen-1:0] imem_rdata,
  input  logic            imem_error,
  output logic            issue_valid,
  output logic [xlen-1:0] issue_pc,
  output logic [xlen-1:0] issue_instr,
  output logic            issue_jump,
  output logic [xlen-1:0] issue_target,
  output logic            issue_exception,
  output logic [3:0]      issue_ecause,
  input  logic            wb_enable,
  input  logic [4:0]      wb_addr,
  input  logic [xlen-1:0] wb_data,
  output logic            halted
);

  logic            decode_valid;
  logic            is_jal;
  logic            is_jalr;
  logic            is_branch;
  logic            is_ebreak;
  logic [4:0]      raddr1;
  logic [4:0]      raddr2;
  logic [xlen-1:0] imm;
  bcu_op_type      bcu_op;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic            taken;
  logic            jump_request;
  logic            target_misaligned;

  fetch_control control (
    .clock, .reset,
    .imem_ack, .imem_error, .imem_rdata, .imem_req, .imem_addr,
    .instr(issue_instr), .pc(issue_pc),
    .decode_valid, .is_ebreak, .jump_request, .target_misaligned,
    .target(issue_target),
    .issue_valid, .issue_jump, .issue_exception, .halted, .issue_ecause
  );

  ////////////////////
  // Datapath on the held instruction.

  // Read enables already select x0 inside the decoder.
  predecoder decoder (
    .instr(issue_instr),
    .decode_valid, .rden1(), .rden2(),
    .is_jal, .is_jalr, .is_branch, .is_ebreak,
    .raddr1, .raddr2, .imm, .bcu_op
  );

  register_file registers (
    .clock,
    .raddr1, .raddr2,
    .waddr(wb_addr), .wren(wb_enable), .wdata(wb_data),
    .rdata1, .rdata2
  );

  branch_compare compare (
    .rdata1, .rdata2, .bcu_op, .taken
  );

  address_generator agu (
    .pc(issue_pc), .rdata1, .imm,
    .is_jal, .is_jalr, .is_branch, .taken,
    .target(issue_target), .jump_request, .target_misaligned
  );

endmodule

`default_nettype wire

// File: source/fetch_control.sv
`default_nettype none

module fetch_control
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            imem_ack,
  input  logic            imem_error,
  input  logic [xlen-1:0] imem_rdata,
  output logic            imem_req,
  output logic [xlen-1:0] imem_addr,
  output logic [xlen-1:0] instr,
  output logic [xlen-1:0] pc,
  input  logic            decode_valid,
  input  logic            is_ebreak,
  input  logic            jump_request,
  input  logic            target_misaligned,
  input  logic [xlen-1:0] target,
  output logic            issue_valid,
  output logic            issue_jump,
  output logic            issue_exception,
  output logic            halted,
  output logic [3:0]      issue_ecause
);

  fetch_state_type state;
  logic            fault;   // Memory error of the held instruction.
  logic            capture;
  logic            exception;
  logic [xlen-1:0] next_pc;

  assign imem_addr = pc; // pc only moves in the issue state.
  assign capture   = (state == fetch_request) & imem_req & imem_ack;

  assign issue_valid = (state == fetch_issue);
  assign halted      = (state == fetch_halted);

  ////////////////////
  // Exceptions and next pc.

  assign exception = fault | ~decode_valid | target_misaligned;

  assign issue_exception = issue_valid & exception;
  assign issue_jump      = issue_valid & jump_request & ~exception;

  always_comb begin
    issue_ecause = ecause_misaligned_target;
    if (issue_exception) begin
      if (fault) begin
        issue_ecause = ecause_access_fault;
      end else if (!decode_valid) begin
        issue_ecause = ecause_illegal_instr;
      end else begin
        issue_ecause = ecause_misaligned_target;
      end
    end
  end

  always_comb begin
    if (exception) begin
      next_pc = trap_vector;
    end else if (jump_request) begin
      next_pc = target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  ////////////////////
  // Handshake and state.

  always_ff @(posedge clock) begin
    if (capture) begin
      fault <= imem_error;
      instr <= imem_error ? nop_instr : imem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_request;
      pc <= reset_vector;
      imem_req <= 1'b0;
    end else begin
      case (state)
        fetch_request: begin
          if (!imem_req) begin
            imem_req <= ~imem_ack; // Rise only once ack is low.
          end else if (imem_ack) begin
            imem_req <= 1'b0;
            state <= fetch_release;
          end
        end
        fetch_release: begin
          if (!imem_ack) begin
            state <= fetch_issue;
          end
        end
        fetch_issue: begin
          pc <= next_pc;
          if (is_ebreak) begin
            state <= fetch_halted;
          end else begin
            imem_req <= 1'b1; // ack was seen low in release.
            state <= fetch_request;
          end
        end
        fetch_halted: state <= fetch_halted; // Left only by reset.
        default: state <= fetch_request;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
  input  logic        clock,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  logic [4:0]  waddr,
  input  logic        wren,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clock) begin
    if (wren && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-first reads.
  always_comb begin
    if (raddr1 == 5'd0) begin
      rdata1 = '0;
    end else if (wren && waddr == raddr1) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == 5'd0) begin
      rdata2 = '0;
    end else if (wren && waddr == raddr2) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

`default_nettype wire

// File: source/address_generator.sv
`default_nettype none

module address_generator
  import riscv_isa_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rdata1,
  input  logic [xlen-1:0] imm,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_branch,
  input  logic            taken,
  output logic [xlen-1:0] target,
  output logic            jump_request,
  output logic            target_misaligned
);

  logic [xlen-1:0] base;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] raw_target;

  ////////////////////
  // Target arithmetic.

  assign base = is_jalr ? rdata1 : pc; // jalr is register relative.
  assign sum  = base + imm;

  assign raw_target = is_jalr ? {sum[xlen-1:1], 1'b0} : sum;

  ////////////////////
  // Jump decision.

  assign jump_request = is_jal | is_jalr | (is_branch & taken);

  assign target = jump_request ? raw_target : '0;

  // Without the compressed set every target must be word aligned.
  assign target_misaligned = jump_request & raw_target[1];

endmodule

`default_nettype wire

// File: source/branch_compare.sv
`default_nettype none

module branch_compare
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic [xlen-1:0] rdata1,
  input  logic [xlen-1:0] rdata2,
  input  bcu_op_type      bcu_op,
  output logic            taken
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal         = (rdata1 == rdata2);
  assign less_signed   = ($signed(rdata1) < $signed(rdata2));
  assign less_unsigned = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      bcu_eq:  taken = equal;
      bcu_ne:  taken = ~equal;
      bcu_lt:  taken = less_signed;
      bcu_ge:  taken = ~less_signed;
      bcu_ltu: taken = less_unsigned;
      bcu_geu: taken = ~less_unsigned;
      default: taken = 1'b0; // Not a branch.
    endcase
  end

endmodule

`default_nettype wire

// File: source/predecoder.sv
`default_nettype none

module predecoder
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic [xlen-1:0] instr,
  output logic            decode_valid,
  output logic            rden1,
  output logic            rden2,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            is_branch,
  output logic            is_ebreak,
  output logic [4:0]      raddr1,
  output logic [4:0]      raddr2,
  output logic [xlen-1:0] imm,
  output bcu_op_type      bcu_op
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // Sign-extended immediates.
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign is_ebreak = (instr == ebreak_instr);

  // Unused read ports select x0.
  assign raddr1 = rden1 ? instr[19:15] : 5'd0;
  assign raddr2 = rden2 ? instr[24:20] : 5'd0;

  always_comb begin
    decode_valid = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    is_branch = 1'b0;
    imm = '0;
    bcu_op = bcu_none;
    case (opcode)
      opcode_lui, opcode_auipc, opcode_system: decode_valid = 1'b1;
      opcode_jal: begin
        decode_valid = 1'b1;
        is_jal = 1'b1;
        imm = imm_j;
      end
      opcode_jalr: begin
        decode_valid = 1'b1;
        is_jalr = 1'b1;
        rden1 = 1'b1;
        imm = imm_i;
      end
      opcode_op_imm, opcode_load: begin
        decode_valid = 1'b1;
        rden1 = 1'b1;
        imm = imm_i;
      end
      opcode_op, opcode_store: begin
        decode_valid = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      opcode_branch: begin
        decode_valid = 1'b1;
        is_branch = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        imm = imm_b;
        case (funct3)
          funct3_beq:  bcu_op = bcu_eq;
          funct3_bne:  bcu_op = bcu_ne;
          funct3_blt:  bcu_op = bcu_lt;
          funct3_bge:  bcu_op = bcu_ge;
          funct3_bltu: bcu_op = bcu_ltu;
          funct3_bgeu: bcu_op = bcu_geu;
          default:     decode_valid = 1'b0; // 010 and 011 are reserved.
        endcase
      end
      default: decode_valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam logic [31:0] reset_vector = 32'h0000_0000; // First fetch address.
  localparam logic [31:0] trap_vector  = 32'h0000_0100; // Target of every exception.

  ////////////////////
  // Branch compare operations.

  typedef enum logic [2:0] {
    bcu_none,
    bcu_eq,
    bcu_ne,
    bcu_lt,
    bcu_ge,
    bcu_ltu,
    bcu_geu
  } bcu_op_type;

  ////////////////////
  // Fetch controller states.

  typedef enum logic [1:0] {
    fetch_request, // req high, waiting for ack.
    fetch_release, // req low, waiting for ack to drop.
    fetch_issue,   // Instruction registered, one cycle.
    fetch_halted
  } fetch_state_type;

endpackage

`default_nettype wire

// File: source/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

  localparam int xlen = 32; // Register and address width.

  ////////////////////
  // Major opcodes.

  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_system = 7'b1110011;

  ////////////////////
  // Branch conditions in funct3.

  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  ////////////////////
  // Exception causes.

  localparam logic [3:0] ecause_misaligned_target = 4'd0;
  localparam logic [3:0] ecause_access_fault      = 4'd1;
  localparam logic [3:0] ecause_illegal_instr     = 4'd2;

  // Fixed instruction words.
  localparam logic [31:0] nop_instr    = 32'h0000_0013; // addi x0,x0,0.
  localparam logic [31:0] ebreak_instr = 32'h0010_0073;

endpackage

`default_nettype wire
